// File: list.f
+incdir+sim
hw/dm_reg_pkg.sv
hw/dmi_pkg.sv
hw/dmi_resp_fifo.sv
hw/dm_csr_decode.sv
hw/dm_ctrl_regs.sv
hw/dm_abstract_regs.sv
hw/dm_top.sv
sim/tb_dm_top.sv

// File: run.sh
#!/bin/sh
# build and run the debug module testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_dm_top \
  -Mdir build/obj -o tb_dm_top

./build/obj/tb_dm_top | tee build/sim.log

# a missing pass line fails the script
grep -q "TESTBENCH PASSED" build/sim.log

// File: sim/tb_dm_ref.svh
/*
 * Reference model and helpers for the debug module testbench.
 * Included inside the testbench module. Holds the stimulus and model state
 * types, the expected-value function, the LFSR and the value check task.
 */
`ifndef TB_DM_REF_SVH
`define TB_DM_REF_SVH

// inputs of one clock cycle, as applied to the DUT
typedef struct packed {
  logic        valid;
  logic [6:0]  addr;
  logic [1:0]  op;
  logic [31:0] wdata;
  logic        resp_ready;
  logic [3:0]  halted;
  logic [3:0]  unavail;
  logic [3:0]  resumeack;
  logic        busy;
  logic        err_valid;
  logic [2:0]  err;
  logic        data_valid;
  logic [63:0] load;
} stim_t;

typedef struct packed {
  logic        haltreq;
  logic        resumereq;
  logic [9:0]  hartsel;
  logic        ndmreset;
  logic        dmactive;
  logic [2:0]  cmderr;
  logic [31:0] command;
  logic        cmd_valid;
  logic [63:0] data;
} model_t;

logic [31:0] lfsr_q = 32'hc60d308f;
int          errors = 0;
int          checks = 0;

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] rand_bits(input int unsigned n);
  logic [31:0] r;
  r = '0;
  for (int unsigned i = 0; i < n; i++) begin
    lfsr_q = lfsr_next(lfsr_q);
    r      = {r[30:0], lfsr_q[0]};
  end
  return r;
endfunction

function automatic logic [3:0] hart_onehot(input logic [9:0] sel, input logic en);
  if (en && sel < 10'd4) begin
    return 4'b0001 << sel[1:0];
  end
  return 4'b0000;
endfunction

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("** Error: %s = 0x%0h, expected 0x%0h (time %0t)", name, got, exp, $time);
  end
endtask

// --------------------------------------------------
// expected read word and next state for one clock edge
// --------------------------------------------------
function automatic logic [31:0] ref_model(input model_t m, input stim_t s, input logic acc,
                                          output model_t n, output logic clr);
  logic [7:0]  a;
  logic        wr;
  logic        rd;
  logic        e;
  logic        h;
  logic        u;
  logic        r;
  logic        run;
  logic        busy_hit;
  logic [31:0] word;
  a        = {1'b0, s.addr};
  wr       = acc && (s.op == 2'h2);
  rd       = acc && (s.op == 2'h1);
  e        = (m.hartsel < 10'd4);
  h        = e && s.halted[m.hartsel[1:0]];
  u        = e && s.unavail[m.hartsel[1:0]];
  r        = e && s.resumeack[m.hartsel[1:0]];
  run      = e && !h && !u;
  busy_hit = 1'b0;
  word     = '0;
  if (rd) begin
    case (a)
      8'h04: word = m.data[31:0];
      8'h05: word = m.data[63:32];
      8'h10: word = {m.haltreq, m.resumereq, 4'b0, m.hartsel, 14'b0, m.ndmreset, m.dmactive};
      8'h11: word = {14'b0, r, r, !e, !e, u, u, run, run, h && !u, h && !u, 1'b1, 3'b0, 4'h2};
      8'h16: word = {19'b0, s.busy, 1'b0, m.cmderr, 4'b0, 4'h2};
      default: word = '0;
    endcase
  end
  clr = wr && (a == 8'h10) && m.dmactive && !m.resumereq && s.wdata[30];
  n   = m;
  n.cmd_valid = 1'b0;
  if (!m.dmactive) begin
    // everything but dmactive held clear
    n          = '0;
    n.dmactive = wr && (a == 8'h10) && s.wdata[0];
  end else begin
    if (wr && a == 8'h10) begin
      n.haltreq   = s.wdata[31];
      n.resumereq = s.wdata[30];
      n.hartsel   = s.wdata[25:16];
      n.ndmreset  = s.wdata[1];
      n.dmactive  = s.wdata[0];
    end
    if (m.resumereq && r) begin
      n.resumereq = 1'b0;
    end
    busy_hit = s.busy && ((wr && (a == 8'h04 || a == 8'h05 || a == 8'h16 || a == 8'h17)) ||
                          (rd && (a == 8'h04 || a == 8'h05)));
    if (!s.busy && wr) begin
      case (a)
        8'h17: begin
          n.command   = s.wdata;
          n.cmd_valid = 1'b1;
        end
        8'h04: n.data[31:0]  = s.wdata;
        8'h05: n.data[63:32] = s.wdata;
        8'h16: n.cmderr      = m.cmderr & ~s.wdata[10:8];
        default: ;
      endcase
    end
    if (busy_hit && m.cmderr == 3'd0) begin
      n.cmderr = 3'd1;
    end
    if (s.err_valid) begin
      n.cmderr = s.err;
    end
    if (s.data_valid) begin
      n.data = s.load;
    end
  end
  return word;
endfunction

`endif

// File: sim/tb_dm_top.sv
/*
 * Testbench of the debug module register front end.
 * Drives DMI requests and hart inputs one cycle at a time, predicts every
 * response and control output with the reference model and compares them.
 */
module tb_dm_top import dm_reg_pkg::*, dmi_pkg::*;;

  localparam int unsigned NrHarts   = 4;
  localparam int unsigned Depth     = 2;
  localparam int          ClkPeriod = 4;
  localparam int          N1        = 24;
  localparam int          N2        = 24;
  localparam int          N4        = 8;
  localparam int          N5        = 40;
  localparam int          NumReqs   = 1 + 2 * N1 + 3 * N2 + 6 + 3 * N4 + 7 + 3 + N5 + 9;
  localparam logic [1:0]  OpRead    = 2'h1;
  localparam logic [1:0]  OpWrite   = 2'h2;

  `include "tb_dm_ref.svh"

  logic        clk_i = 1'b0;
  logic        rst_ni;
  stim_t       cur;
  stim_t       nxt;
  model_t      mdl;
  int          fifo_cnt;
  logic        last_acc;
  logic [31:0] exp_q[$];
  logic [31:0] exp_word;

  dmi_req_t                   req_drv;
  cmderr_e                    err_drv;
  logic                       dmi_req_ready_o;
  logic                       dmi_resp_valid_o;
  dmi_resp_t                  dmi_resp_o;
  logic                       ndmreset_o;
  logic                       dmactive_o;
  logic [NrHarts-1:0]         haltreq_o;
  logic [NrHarts-1:0]         resumereq_o;
  logic                       clear_resumeack_o;
  logic                       cmd_valid_o;
  command_t                   cmd_o;
  logic [DataCount-1:0][31:0] data_o;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  always_comb begin
    req_drv.addr = cur.addr;
    req_drv.op   = dtm_op_e'(cur.op);
    req_drv.data = cur.wdata;
    err_drv      = cmderr_e'(cur.err);
  end

  dm_top #(
    .NrHarts (NrHarts),
    .Depth   (Depth)
  ) i_dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .dmi_req_valid_i   (cur.valid),
    .dmi_req_ready_o   (dmi_req_ready_o),
    .dmi_req_i         (req_drv),
    .dmi_resp_valid_o  (dmi_resp_valid_o),
    .dmi_resp_ready_i  (cur.resp_ready),
    .dmi_resp_o        (dmi_resp_o),
    .ndmreset_o        (ndmreset_o),
    .dmactive_o        (dmactive_o),
    .halted_i          (cur.halted),
    .unavailable_i     (cur.unavail),
    .resumeack_i       (cur.resumeack),
    .haltreq_o         (haltreq_o),
    .resumereq_o       (resumereq_o),
    .clear_resumeack_o (clear_resumeack_o),
    .cmd_valid_o       (cmd_valid_o),
    .cmd_o             (cmd_o),
    .cmdbusy_i         (cur.busy),
    .cmderror_valid_i  (cur.err_valid),
    .cmderror_i        (err_drv),
    .data_o            (data_o),
    .data_i            (cur.load),
    .data_valid_i      (cur.data_valid)
  );

  // --------------------------------------------------
  // one clock cycle: drive, check outputs, step the model
  // --------------------------------------------------
  task automatic run_cycle();
    logic        acc;
    logic        clr;
    logic [31:0] word;
    model_t      n;
    @(posedge clk_i);
    #1;
    cur            = nxt;
    nxt.err_valid  = 1'b0;
    nxt.data_valid = 1'b0;
    @(negedge clk_i);
    check_value("dmi_req_ready_o", 64'(dmi_req_ready_o), 64'(fifo_cnt < Depth));
    check_value("dmi_resp_valid_o", 64'(dmi_resp_valid_o), 64'(fifo_cnt != 0));
    check_value("dmactive_o", 64'(dmactive_o), 64'(mdl.dmactive));
    check_value("ndmreset_o", 64'(ndmreset_o), 64'(mdl.ndmreset));
    check_value("haltreq_o", 64'(haltreq_o), 64'(hart_onehot(mdl.hartsel, mdl.haltreq)));
    check_value("resumereq_o", 64'(resumereq_o), 64'(hart_onehot(mdl.hartsel, mdl.resumereq)));
    check_value("cmd_valid_o", 64'(cmd_valid_o), 64'(mdl.cmd_valid));
    check_value("cmd_o", 64'(cmd_o), 64'(mdl.command));
    check_value("data_o", 64'(data_o), mdl.data);
    acc  = cur.valid && (fifo_cnt < Depth);
    word = ref_model(mdl, cur, acc, n, clr);
    check_value("clear_resumeack_o", 64'(clear_resumeack_o), 64'(clr));
    mdl = n;
    if (acc) begin
      exp_q.push_back(word);
    end
    fifo_cnt = fifo_cnt + int'(acc) - int'(cur.resp_ready && fifo_cnt != 0);
    last_acc = acc;
  endtask

  // holds the request until accepted, then releases it
  task automatic dmi_access(input logic [1:0] op, input logic [6:0] addr, input logic [31:0] data);
    nxt.valid = 1'b1;
    nxt.op    = op;
    nxt.addr  = addr;
    nxt.wdata = data;
    last_acc  = 1'b0;
    while (!last_acc) begin
      run_cycle();
      if (!last_acc) begin
        nxt.resp_ready = 1'b1;
      end
    end
    nxt.valid = 1'b0;
  endtask

  function automatic logic [6:0] pick_addr(input logic [2:0] sel);
    case (sel)
      3'd0: return 7'h04;
      3'd1: return 7'h05;
      3'd2: return 7'h10;
      3'd3: return 7'h11;
      3'd4: return 7'h16;
      3'd5: return 7'h17;
      default: return 7'(rand_bits(7));
    endcase
  endfunction

  // responses leave the queue in request order
  always @(negedge clk_i) begin
    if (rst_ni && dmi_resp_valid_o && cur.resp_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("a response arrived with no request outstanding (time %0t)", $time);
      end else begin
        exp_word = exp_q.pop_front();
        check_value("dmi_resp_o.data", 64'(dmi_resp_o.data), 64'(exp_word));
        check_value("dmi_resp_o.resp", 64'(dmi_resp_o.resp), 64'(0));
      end
    end
  end

  initial begin
    #(NumReqs * 20 * ClkPeriod);
    $display("timeout: the tests did not finish within %0d cycles", NumReqs * 20);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    logic [31:0] w;
    logic [6:0]  addr;
    logic [1:0]  op;
    nxt            = '0;
    nxt.resp_ready = 1'b1;
    cur            = nxt;
    mdl            = '0;
    fifo_cnt       = 0;
    last_acc       = 1'b0;
    rst_ni         = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    dmi_access(OpWrite, 7'h10, 32'h1);

    // dmcontrol fields and hart requests
    for (int i = 0; i < N1; i++) begin
      nxt.resumeack = 4'(rand_bits(4));
      w             = rand_bits(32);
      w[25:16]      = 10'(rand_bits(3));
      w[0]          = 1'b1;
      dmi_access(OpWrite, 7'h10, w);
      dmi_access(OpRead, 7'h10, '0);
    end

    // dmstatus against random hart status
    for (int i = 0; i < N2; i++) begin
      nxt.halted    = 4'(rand_bits(4));
      nxt.unavail   = 4'(rand_bits(4));
      nxt.resumeack = 4'(rand_bits(4));
      w             = 32'h1;
      w[30]         = 1'(rand_bits(1));
      w[25:16]      = 10'(rand_bits(3));
      dmi_access(OpWrite, 7'h10, w);
      dmi_access(OpRead, 7'h11, '0);
      dmi_access(OpRead, 7'h10, '0);
    end

    // command launch, busy error and write-1-to-clear
    nxt.busy      = 1'b0;
    nxt.resumeack = 4'h0;
    w             = rand_bits(32);
    dmi_access(OpWrite, 7'h17, w);
    run_cycle();
    run_cycle();
    check_value("cmd_o", 64'(cmd_o), 64'(w));
    dmi_access(OpRead, 7'h17, '0);
    nxt.busy = 1'b1;
    dmi_access(OpWrite, 7'h17, rand_bits(32));
    dmi_access(OpRead, 7'h16, '0);
    check_value("cmd_o", 64'(cmd_o), 64'(w));
    nxt.busy = 1'b0;
    dmi_access(OpWrite, 7'h16, 32'h700);
    dmi_access(OpRead, 7'h16, '0);

    // data words, hart load and hart error
    for (int i = 0; i < N4; i++) begin
      addr = 7'h04 + 7'(rand_bits(1));
      dmi_access(OpWrite, addr, rand_bits(32));
      dmi_access(OpRead, 7'h04, '0);
      dmi_access(OpRead, 7'h05, '0);
    end
    nxt.load       = {rand_bits(32), rand_bits(32)};
    nxt.data_valid = 1'b1;
    run_cycle();
    dmi_access(OpRead, 7'h04, '0);
    dmi_access(OpRead, 7'h05, '0);
    nxt.err       = 3'(rand_bits(3));
    nxt.err_valid = 1'b1;
    run_cycle();
    dmi_access(OpRead, 7'h16, '0);
    dmi_access(OpWrite, 7'h16, 32'h700);
    nxt.busy = 1'b1;
    dmi_access(OpRead, 7'h04, '0);
    dmi_access(OpRead, 7'h16, '0);
    nxt.busy = 1'b0;
    dmi_access(OpWrite, 7'h16, 32'h700);

    // back-pressure on the response queue, starting empty
    while (fifo_cnt != 0) begin
      run_cycle();
    end
    nxt.resp_ready = 1'b0;
    dmi_access(OpRead, 7'h10, '0);
    dmi_access(OpRead, 7'h16, '0);
    nxt.valid = 1'b1;
    nxt.op    = OpRead;
    nxt.addr  = 7'h11;
    repeat (3) run_cycle();
    check_value("dmi_req_ready_o", 64'(dmi_req_ready_o), 64'(0));
    nxt.resp_ready = 1'b1;
    dmi_access(OpRead, 7'h11, '0);

    // random mix of addresses, operations and side inputs
    for (int i = 0; i < N5; i++) begin
      addr = pick_addr(3'(rand_bits(3)));
      op   = 2'(rand_bits(2));
      w    = rand_bits(32);
      if (addr == 7'h10) begin
        w[0] = (rand_bits(2) != 0);
      end
      nxt.busy       = (rand_bits(2) == 0);
      nxt.halted     = 4'(rand_bits(4));
      nxt.unavail    = 4'(rand_bits(4));
      nxt.resumeack  = 4'(rand_bits(4));
      nxt.resp_ready = 1'(rand_bits(1));
      nxt.err_valid  = (rand_bits(3) == 0);
      nxt.err        = 3'(rand_bits(3));
      dmi_access(op, addr, w);
    end

    // dropping dmactive clears the register set
    nxt.busy       = 1'b0;
    nxt.resp_ready = 1'b1;
    dmi_access(OpWrite, 7'h10, 32'h1);
    dmi_access(OpWrite, 7'h10, 32'h8000_0003);
    dmi_access(OpWrite, 7'h04, rand_bits(32));
    nxt.err       = 3'd3;
    nxt.err_valid = 1'b1;
    dmi_access(OpWrite, 7'h10, 32'h0);
    run_cycle();
    check_value("dmactive_o", 64'(dmactive_o), 64'(0));
    dmi_access(OpRead, 7'h10, '0);
    dmi_access(OpRead, 7'h16, '0);
    dmi_access(OpRead, 7'h04, '0);
    dmi_access(OpRead, 7'h05, '0);
    dmi_access(OpRead, 7'h17, '0);

    // drain the queue
    while (fifo_cnt != 0) begin
      run_cycle();
    end
    run_cycle();
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected responses never arrived", exp_q.size());
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: hw/dm_top.sv
/*
 * Register front end of the debug module.
 * Connects the DMI request decoder, the response queue and the run control
 * and abstract command register blocks.
 */
module dm_top import dm_reg_pkg::*, dmi_pkg::*; #(
  parameter int unsigned NrHarts = 4,
  parameter int unsigned Depth   = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // DMI
  input  logic                       dmi_req_valid_i,
  output logic                       dmi_req_ready_o,
  input  dmi_req_t                   dmi_req_i,
  output logic                       dmi_resp_valid_o,
  input  logic                       dmi_resp_ready_i,
  output dmi_resp_t                  dmi_resp_o,
  // global control
  output logic                       ndmreset_o,
  output logic                       dmactive_o,
  // hart status and control
  input  logic [NrHarts-1:0]         halted_i,
  input  logic [NrHarts-1:0]         unavailable_i,
  input  logic [NrHarts-1:0]         resumeack_i,
  output logic [NrHarts-1:0]         haltreq_o,
  output logic [NrHarts-1:0]         resumereq_o,
  output logic                       clear_resumeack_o,
  // abstract commands
  output logic                       cmd_valid_o,
  output command_t                   cmd_o,
  input  logic                       cmdbusy_i,
  input  logic                       cmderror_valid_i,
  input  cmderr_e                    cmderror_i,
  output logic [DataCount-1:0][31:0] data_o,
  input  logic [DataCount-1:0][31:0] data_i,
  input  logic                       data_valid_i
);

  csr_wr_t     csr_wr;
  dmcontrol_t  dmcontrol;
  dmstatus_t   dmstatus;
  abstractcs_t abstractcs;
  logic        fifo_full, fifo_empty, push;
  logic [31:0] push_data, resp_data;

  assign dmi_resp_valid_o = ~fifo_empty;
  assign dmi_resp_o       = '{data: resp_data, resp: DTM_SUCCESS};

  dm_csr_decode i_csr_decode (
    .dmi_req_valid_i (dmi_req_valid_i),
    .dmi_req_i       (dmi_req_i),
    .dmi_req_ready_o (dmi_req_ready_o),
    .fifo_full_i     (fifo_full),
    .push_o          (push),
    .push_data_o     (push_data),
    .csr_wr_o        (csr_wr),
    .dmcontrol_i     (dmcontrol),
    .dmstatus_i      (dmstatus),
    .abstractcs_i    (abstractcs),
    .data_i          (data_o)
  );

  dmi_resp_fifo #(
    .Depth (Depth)
  ) i_resp_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (push),
    .data_i  (push_data),
    .full_o  (fifo_full),
    .pop_i   (dmi_resp_ready_i),
    .empty_o (fifo_empty),
    .data_o  (resp_data)
  );

  dm_ctrl_regs #(
    .NrHarts (NrHarts)
  ) i_ctrl_regs (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .csr_wr_i          (csr_wr),
    .halted_i          (halted_i),
    .unavailable_i     (unavailable_i),
    .resumeack_i       (resumeack_i),
    .haltreq_o         (haltreq_o),
    .resumereq_o       (resumereq_o),
    .clear_resumeack_o (clear_resumeack_o),
    .ndmreset_o        (ndmreset_o),
    .dmactive_o        (dmactive_o),
    .dmcontrol_o       (dmcontrol),
    .dmstatus_o        (dmstatus)
  );

  dm_abstract_regs i_abstract_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .csr_wr_i         (csr_wr),
    .dmactive_i       (dmactive_o),
    .cmdbusy_i        (cmdbusy_i),
    .cmderror_valid_i (cmderror_valid_i),
    .cmderror_i       (cmderror_i),
    .data_valid_i     (data_valid_i),
    .data_i           (data_i),
    .cmd_valid_o      (cmd_valid_o),
    .cmd_o            (cmd_o),
    .data_o           (data_o),
    .abstractcs_o     (abstractcs)
  );

endmodule

// File: hw/dm_abstract_regs.sv
/*
 * Abstract command registers of the debug module.
 * Holds the last command, the cmderr field and the data words. Accesses that
 * collide with a running command are dropped and flag a busy error.
 * A hart error report and a data load win over a DMI update in the same cycle.
 */
module dm_abstract_regs import dm_reg_pkg::*, dmi_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  csr_wr_t                    csr_wr_i,
  input  logic                       dmactive_i,
  input  logic                       cmdbusy_i,
  input  logic                       cmderror_valid_i,
  input  cmderr_e                    cmderror_i,
  input  logic                       data_valid_i,
  input  logic [DataCount-1:0][31:0] data_i,
  output logic                       cmd_valid_o,
  output command_t                   cmd_o,
  output logic [DataCount-1:0][31:0] data_o,
  output abstractcs_t                abstractcs_o
);

  cmderr_e                    cmderr_d, cmderr_q;
  command_t                   command_d, command_q;
  logic                       cmd_valid_d, cmd_valid_q;
  logic [DataCount-1:0][31:0] data_d, data_q;
  logic                       busy_err;

  always_comb begin
    cmderr_d    = cmderr_q;
    command_d   = command_q;
    data_d      = data_q;
    cmd_valid_d = 1'b0;
    busy_err    = cmdbusy_i & (csr_wr_i.command_we | csr_wr_i.data_we |
                               csr_wr_i.data_re | csr_wr_i.abstractcs_we);

    if (!cmdbusy_i) begin
      if (csr_wr_i.command_we) begin
        cmd_valid_d = 1'b1;
        command_d   = csr_wr_i.wdata.command;
      end
      if (csr_wr_i.data_we) begin
        data_d[csr_wr_i.data_idx] = csr_wr_i.wdata;
      end
      // write one to clear
      if (csr_wr_i.abstractcs_we) begin
        cmderr_d = cmderr_e'(cmderr_q & ~csr_wr_i.wdata.abstractcs.cmderr);
      end
    end

    // first error sticks
    if (busy_err && cmderr_q == CmdErrNone) begin
      cmderr_d = CmdErrBusy;
    end
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
    if (data_valid_i) begin
      data_d = data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmderr_q    <= CmdErrNone;
      command_q   <= '0;
      cmd_valid_q <= 1'b0;
      data_q      <= '0;
    end else if (!dmactive_i) begin
      cmderr_q    <= CmdErrNone;
      command_q   <= '0;
      cmd_valid_q <= 1'b0;
      data_q      <= '0;
    end else begin
      cmderr_q    <= cmderr_d;
      command_q   <= command_d;
      cmd_valid_q <= cmd_valid_d;
      data_q      <= data_d;
    end
  end

  always_comb begin
    abstractcs_o           = '0;
    abstractcs_o.datacount = 4'(DataCount);
    abstractcs_o.busy      = cmdbusy_i;
    abstractcs_o.cmderr    = cmderr_q;
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign data_o      = data_q;

endmodule

// File: hw/dm_ctrl_regs.sv
/*
 * Run control part of the debug module.
 * Stores dmcontrol, drives the per-hart halt and resume requests for the
 * selected hart and builds dmstatus from the hart status inputs.
 * While dmactive is low the register is held clear except for dmactive.
 */
module dm_ctrl_regs import dm_reg_pkg::*, dmi_pkg::*; #(
  parameter int unsigned NrHarts = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  csr_wr_t            csr_wr_i,
  // hart status
  input  logic [NrHarts-1:0] halted_i,
  input  logic [NrHarts-1:0] unavailable_i,
  input  logic [NrHarts-1:0] resumeack_i,
  // hart control
  output logic [NrHarts-1:0] haltreq_o,
  output logic [NrHarts-1:0] resumereq_o,
  output logic               clear_resumeack_o,
  output logic               ndmreset_o,
  output logic               dmactive_o,
  // read words
  output dmcontrol_t         dmcontrol_o,
  output dmstatus_t          dmstatus_o
);

  dmcontrol_t         dmcontrol_d, dmcontrol_q;
  dmcontrol_t         wr;
  logic [NrHarts-1:0] hart_sel_oh;
  logic               hart_exists;
  logic               sel_halted, sel_unavail, sel_resumeack;

  // --------------------------------------------------
  // hart select
  // --------------------------------------------------
  always_comb begin
    hart_sel_oh = '0;
    for (int unsigned h = 0; h < NrHarts; h++) begin
      hart_sel_oh[h] = (dmcontrol_q.hartsello == 10'(h));
    end
  end

  // all zero for a nonexistent hart
  assign hart_exists   = |hart_sel_oh;
  assign sel_halted    = |(halted_i & hart_sel_oh);
  assign sel_unavail   = |(unavailable_i & hart_sel_oh);
  assign sel_resumeack = |(resumeack_i & hart_sel_oh);

  assign haltreq_o   = hart_sel_oh & {NrHarts{dmcontrol_q.haltreq}};
  assign resumereq_o = hart_sel_oh & {NrHarts{dmcontrol_q.resumereq}};

  // --------------------------------------------------
  // dmcontrol
  // --------------------------------------------------
  always_comb begin
    wr          = csr_wr_i.wdata.dmcontrol;
    dmcontrol_d = dmcontrol_q;
    if (csr_wr_i.dmcontrol_we) begin
      // keep the supported fields only
      dmcontrol_d           = '0;
      dmcontrol_d.haltreq   = wr.haltreq;
      dmcontrol_d.resumereq = wr.resumereq;
      dmcontrol_d.hartsello = wr.hartsello;
      dmcontrol_d.ndmreset  = wr.ndmreset;
      dmcontrol_d.dmactive  = wr.dmactive;
    end
    clear_resumeack_o = dmcontrol_q.dmactive & ~dmcontrol_q.resumereq & dmcontrol_d.resumereq;
    // request served once the selected hart acknowledges
    if (dmcontrol_q.resumereq && sel_resumeack) begin
      dmcontrol_d.resumereq = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q <= '0;
    end else if (!dmcontrol_q.dmactive) begin
      dmcontrol_q          <= '0;
      dmcontrol_q.dmactive <= dmcontrol_d.dmactive;
    end else begin
      dmcontrol_q <= dmcontrol_d;
    end
  end

  assign ndmreset_o  = dmcontrol_q.ndmreset;
  assign dmactive_o  = dmcontrol_q.dmactive;
  assign dmcontrol_o = dmcontrol_q;

  // --------------------------------------------------
  // dmstatus
  // --------------------------------------------------
  always_comb begin
    dmstatus_o                = '0;
    dmstatus_o.version        = DbgVersion013;
    dmstatus_o.authenticated  = 1'b1;
    dmstatus_o.allnonexistent = ~hart_exists;
    dmstatus_o.anynonexistent = ~hart_exists;
    dmstatus_o.allunavail     = sel_unavail;
    dmstatus_o.anyunavail     = sel_unavail;
    dmstatus_o.allresumeack   = sel_resumeack;
    dmstatus_o.anyresumeack   = sel_resumeack;
    // halted and running exclude unavailable
    dmstatus_o.allhalted      = sel_halted & ~sel_unavail;
    dmstatus_o.anyhalted      = sel_halted & ~sel_unavail;
    dmstatus_o.allrunning     = hart_exists & ~sel_halted & ~sel_unavail;
    dmstatus_o.anyrunning     = hart_exists & ~sel_halted & ~sel_unavail;
  end

endmodule

// File: hw/dm_csr_decode.sv
/*
 * DMI request decoder of the debug module.
 * Accepts a request whenever the response queue has room, turns a write into
 * one register strobe and turns a read into the selected register word.
 * Every accepted request pushes exactly one response word.
 */
module dm_csr_decode import dm_reg_pkg::*, dmi_pkg::*; (
  input  logic                       dmi_req_valid_i,
  input  dmi_req_t                   dmi_req_i,
  output logic                       dmi_req_ready_o,
  // response queue
  input  logic                       fifo_full_i,
  output logic                       push_o,
  output logic [31:0]                push_data_o,
  // register blocks
  output csr_wr_t                    csr_wr_o,
  input  logic [31:0]                dmcontrol_i,
  input  logic [31:0]                dmstatus_i,
  input  logic [31:0]                abstractcs_i,
  input  logic [DataCount-1:0][31:0] data_i
);

  dm_csr_e    csr_addr;
  logic [7:0] data_off;
  logic       accept;
  logic       is_data;

  assign dmi_req_ready_o = ~fifo_full_i;
  assign accept          = dmi_req_valid_i & ~fifo_full_i;
  assign push_o          = accept;

  assign csr_addr = dm_csr_e'({1'b0, dmi_req_i.addr});
  assign data_off = 8'(csr_addr) - 8'(Data0);
  assign is_data  = (data_off < 8'(DataCount));

  always_comb begin
    csr_wr_o          = '0;
    csr_wr_o.wdata    = dmi_req_i.data;
    csr_wr_o.data_idx = data_off[0];
    // writes and unmapped reads answer zero
    push_data_o       = '0;

    if (accept && dmi_req_i.op == DTM_WRITE) begin
      csr_wr_o.data_we = is_data;
      case (csr_addr)
        DMControl:  csr_wr_o.dmcontrol_we  = 1'b1;
        AbstractCS: csr_wr_o.abstractcs_we = 1'b1;
        Command:    csr_wr_o.command_we    = 1'b1;
        default: ;
      endcase
    end

    if (accept && dmi_req_i.op == DTM_READ) begin
      if (is_data) begin
        csr_wr_o.data_re = 1'b1;
        push_data_o      = data_i[data_off[0]];
      end
      // command reads back as zero
      case (csr_addr)
        DMControl:  push_data_o = dmcontrol_i;
        DMStatus:   push_data_o = dmstatus_i;
        AbstractCS: push_data_o = abstractcs_i;
        default: ;
      endcase
    end
  end

endmodule

// File: hw/dmi_resp_fifo.sv
/*
 * Response queue of the DMI.
 * Holds one 32-bit word per accepted request until the debugger pops it.
 * A push while full and a pop while empty are ignored.
 */
module dmi_resp_fifo #(
  parameter int unsigned Depth = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        push_i,
  input  logic [31:0] data_i,
  output logic        full_o,
  input  logic        pop_i,
  output logic        empty_o,
  output logic [31:0] data_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [Depth-1:0][31:0] mem_q;
  logic [PtrW-1:0]        rd_ptr_q, wr_ptr_q;
  logic [CntW-1:0]        count_q;
  logic                   do_push, do_pop;

  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: hw/dmi_pkg.sv
/*
 * Transport-side types of the debug module interface.
 * Defines the request and response words seen by the debugger and the
 * write strobe bundle that the decoder hands to the register blocks.
 */
package dmi_pkg;
  import dm_reg_pkg::*;

  typedef enum logic [1:0] {
    DTM_NOP   = 2'h0,
    DTM_READ  = 2'h1,
    DTM_WRITE = 2'h2
  } dtm_op_e;

  typedef enum logic [1:0] {
    DTM_SUCCESS = 2'h0,
    DTM_ERR     = 2'h2,
    DTM_BUSY    = 2'h3
  } dtm_resp_e;

  typedef struct packed {
    logic [6:0]  addr;
    dtm_op_e     op;
    logic [31:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } dmi_resp_t;

  // per-request strobes, valid only in the accepting cycle
  typedef struct packed {
    logic      dmcontrol_we;
    logic      abstractcs_we;
    logic      command_we;
    logic      data_we;
    logic      data_re;
    logic      data_idx;
    dm_wdata_u wdata;
  } csr_wr_t;

endpackage

// File: hw/dm_reg_pkg.sv
/*
 * Register map and field layouts of the debug module register set.
 * Holds the DMI addresses, the 0.13 register structs, the union used to
 * decode one write word in several ways, and the abstract command error codes.
 */
package dm_reg_pkg;

  localparam int unsigned DataCount = 2;
  localparam logic [3:0] DbgVersion013 = 4'h2;

  typedef enum logic [7:0] {
    Data0      = 8'h04,
    Data1      = 8'h05,
    DMControl  = 8'h10,
    DMStatus   = 8'h11,
    AbstractCS = 8'h16,
    Command    = 8'h17
  } dm_csr_e;

  typedef enum logic [2:0] {
    CmdErrNone         = 3'd0,
    CmdErrBusy         = 3'd1,
    CmdErrNotSupported = 3'd2,
    CmdErrException    = 3'd3,
    CmdErrHaltResume   = 3'd4,
    CmdErrBus          = 3'd5,
    CmdErrOther        = 3'd7
  } cmderr_e;

  // hartreset, hasel, hartselhi and the reset-halt bits are not implemented
  typedef struct packed {
    logic        haltreq;
    logic        resumereq;
    logic [3:0]  zero1;
    logic [9:0]  hartsello;
    logic [13:0] zero0;
    logic        ndmreset;
    logic        dmactive;
  } dmcontrol_t;

  typedef struct packed {
    logic [13:0] zero1;
    logic        allresumeack;
    logic        anyresumeack;
    logic        allnonexistent;
    logic        anynonexistent;
    logic        allunavail;
    logic        anyunavail;
    logic        allrunning;
    logic        anyrunning;
    logic        allhalted;
    logic        anyhalted;
    logic        authenticated;
    logic [2:0]  zero0;
    logic [3:0]  version;
  } dmstatus_t;

  typedef struct packed {
    logic [2:0]  zero3;
    logic [4:0]  progbufsize;
    logic [10:0] zero2;
    logic        busy;
    logic        zero1;
    cmderr_e     cmderr;
    logic [3:0]  zero0;
    logic [3:0]  datacount;
  } abstractcs_t;

  typedef struct packed {
    logic [7:0]  cmdtype;
    logic [23:0] control;
  } command_t;

  // one DMI write word, viewed according to the target address
  typedef union packed {
    dmcontrol_t  dmcontrol;
    abstractcs_t abstractcs;
    command_t    command;
  } dm_wdata_u;

endpackage
